// ==== Makefile ====
# Verilator lint and simulation of the interrupt controller control block

VERILATOR    := verilator
TOP          := pic_control_logic_tb
FILELIST     := project.f
BUILD_DIR    := obj_dir
LINT_FLAGS   := --lint-only --timing --assert
SIM_FLAGS    := --binary --timing --assert
SIM_ARGS     := +verilator+error+limit+100
PASS_MESSAGE := *** PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MESSAGE)'

clean:
	rm -rf $(BUILD_DIR)

// ==== logic/acknowledge_sequencer.sv ====
////////////////////////////////////////////////////////////
// Acknowledge and poll sequencing
// Follows the host's INTA pulses and poll reads, latches
// the acknowledged level and drives the request, in-service
// and end-of-interrupt control lines
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module acknowledge_sequencer
    import pic_level_pkg::*;
    import pic_command_pkg::*;
(
    input   logic           clock,
    input   logic           reset,
    input   logic           write_icw1,
    input   logic           interrupt_acknowledge_n,
    input   logic           read,
    input   level_vector_t  interrupt,
    input   level_vector_t  highest_level_in_service,
    input   logic           ocw2_accepted,
    input   logic           poll_command,
    input   logic           nonspecific_eoi,
    input   level_vector_t  specific_eoi,
    input   logic           auto_eoi_config,
    output  ack_state_t     ack_state,
    output  level_vector_t  acknowledged_interrupt,
    output  logic           interrupt_to_cpu,
    output  logic           freeze,
    output  logic           latch_in_service,
    output  level_vector_t  clear_interrupt_request,
    output  level_vector_t  end_of_interrupt
);
    ack_state_t next_ack_state;
    logic       prev_acknowledge_n;
    logic       prev_read;
    logic       acknowledge_fall;
    logic       acknowledge_rise;
    logic       read_fall;
    logic       end_of_ack_sequence;
    logic       end_of_poll;

    always_ff @(posedge clock) begin
        if (reset) begin
            prev_acknowledge_n <= 1'b1;
            prev_read          <= 1'b0;
        end else begin
            prev_acknowledge_n <= interrupt_acknowledge_n;
            prev_read          <= read;
        end
    end

    assign acknowledge_fall =  prev_acknowledge_n & ~interrupt_acknowledge_n;
    assign acknowledge_rise = ~prev_acknowledge_n &  interrupt_acknowledge_n;
    assign read_fall        =  prev_read & ~read;

    always_comb begin
        next_ack_state = ack_state;
        case (ack_state)
            READY: begin
                if (poll_command)
                    next_ack_state = POLL;
                else if ((interrupt != '0) && !ocw2_accepted)
                    next_ack_state = WAIT_ACK;
            end
            WAIT_ACK: begin
                if (poll_command)
                    next_ack_state = POLL;
                else if (acknowledge_fall)
                    next_ack_state = ACK1;
            end
            ACK1: begin
                if (acknowledge_rise)
                    next_ack_state = ACK2;
            end
            ACK2: begin
                if (acknowledge_rise)
                    next_ack_state = READY;
            end
            POLL: begin
                if (read_fall)
                    next_ack_state = READY;
            end
            default: next_ack_state = READY;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset)
            ack_state <= READY;
        else
            ack_state <= next_ack_state;
    end

    // Leaving WAIT_ACK for ACK1 or POLL
    assign latch_in_service = (ack_state == WAIT_ACK) & (next_ack_state != WAIT_ACK);

    assign end_of_ack_sequence = (ack_state != POLL) & (ack_state != READY)
                               & (next_ack_state == READY);
    assign end_of_poll         = (ack_state == POLL) & (next_ack_state == READY);

    always_ff @(posedge clock) begin
        if (reset)
            acknowledged_interrupt <= '0;
        else if (end_of_ack_sequence || end_of_poll)
            acknowledged_interrupt <= '0;
        else if (latch_in_service)
            acknowledged_interrupt <= interrupt;
    end

    // INT holds through a poll
    always_ff @(posedge clock) begin
        if (reset)
            interrupt_to_cpu <= 1'b0;
        else if (next_ack_state == READY)
            interrupt_to_cpu <= 1'b0;
        else if (next_ack_state != POLL)
            interrupt_to_cpu <= 1'b1;
    end

    always_ff @(posedge clock) begin
        if (reset)
            freeze <= 1'b1;
        else
            freeze <= (next_ack_state != READY) && (next_ack_state != WAIT_ACK);
    end

    always_comb begin
        if (write_icw1)
            clear_interrupt_request = '1;
        else if (latch_in_service)
            clear_interrupt_request = interrupt;
        else
            clear_interrupt_request = '0;
    end

    always_comb begin
        if (auto_eoi_config && end_of_ack_sequence)
            end_of_interrupt = acknowledged_interrupt;
        else if (nonspecific_eoi)
            end_of_interrupt = highest_level_in_service;
        else
            end_of_interrupt = specific_eoi;
    end

endmodule

// ==== logic/command_word_decoder.sv ====
////////////////////////////////////////////////////////////
// Host command decoding for the interrupt controller
// Runs the ICW1/ICW2/ICW4 sequence, holds configuration
// and mask, and turns OCW2/OCW3 writes into EOI and poll
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module command_word_decoder
    import pic_level_pkg::*;
    import pic_command_pkg::*;
(
    input   logic           clock,
    input   logic           reset,
    input   logic   [7:0]   data_in,
    input   logic           write_icw1,
    input   logic           write_icw2_4,
    input   logic           write_ocw1,
    input   logic           write_ocw2,
    input   logic           write_ocw3,
    output  vector_base_t   vector_base,
    output  logic           level_triggered_config,
    output  logic           auto_eoi_config,
    output  level_vector_t  interrupt_mask,
    output  logic           ocw2_accepted,
    output  logic           poll_command,
    output  logic           nonspecific_eoi,
    output  level_vector_t  specific_eoi
);
    typedef enum logic [1:0] {
        INIT_READY,
        EXPECT_ICW2,
        EXPECT_ICW4
    } init_state_t;

    init_state_t    init_state;
    init_state_t    next_init_state;
    logic           icw4_needed;
    logic           single_config;
    logic           x86_config;
    logic           ocw_enable;
    logic           write_icw2;
    logic           write_icw4;
    logic           ocw1_accepted;
    logic           ocw3_accepted;
    command_word_u  command;

    assign command = data_in;

    always_comb begin
        next_init_state = init_state;
        if (write_icw1) begin
            next_init_state = EXPECT_ICW2;
        end else if (write_icw2_4) begin
            if ((init_state == EXPECT_ICW2) && icw4_needed)
                next_init_state = EXPECT_ICW4;
            else
                next_init_state = INIT_READY;
        end
    end

    always_ff @(posedge clock) begin
        if (reset)
            init_state <= INIT_READY;
        else
            init_state <= next_init_state;
    end

    assign write_icw2 = write_icw2_4 & (init_state == EXPECT_ICW2);
    assign write_icw4 = write_icw2_4 & (init_state == EXPECT_ICW4);

    // Cascade or MCS-80 settings leave the operation words inert
    assign ocw_enable    = (init_state == INIT_READY) & single_config & x86_config;
    assign ocw1_accepted = write_ocw1 & ocw_enable;
    assign ocw2_accepted = write_ocw2 & ocw_enable;
    assign ocw3_accepted = write_ocw3 & ocw_enable;

    always_ff @(posedge clock) begin
        if (reset) begin
            level_triggered_config <= 1'b0;
            single_config          <= 1'b1;
            icw4_needed            <= 1'b0;
            vector_base            <= '0;
            auto_eoi_config        <= 1'b0;
            x86_config             <= 1'b1;
        end else begin
            // ICW1: LTIM, SNGL, IC4
            if (write_icw1) begin
                level_triggered_config <= data_in[3];
                single_config          <= data_in[1];
                icw4_needed            <= data_in[0];
            end
            // ICW2: T7-T3
            if (write_icw2)
                vector_base <= data_in[7:3];
            // ICW4: AEOI, uPM
            if (write_icw4) begin
                auto_eoi_config <= data_in[1];
                x86_config      <= data_in[0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset)
            interrupt_mask <= '1;
        else if (ocw1_accepted)
            interrupt_mask <= data_in;
    end

    assign nonspecific_eoi = ocw2_accepted & command.ocw2_view.eoi
                           & ~command.ocw2_view.specific;

    always_comb begin
        specific_eoi = '0;
        if (ocw2_accepted && command.ocw2_view.eoi && command.ocw2_view.specific)
            specific_eoi = level_to_onehot(command.ocw2_view.level);
    end

    assign poll_command = ocw3_accepted & command.ocw3_view.poll;

endmodule

// ==== logic/pic_command_pkg.sv ====
////////////////////////////////////////////////////////////
// Command byte layouts and acknowledge encodings
// The OCW2 and OCW3 views share one bus byte, and the
// acknowledge states are shared by sequencer and bus driver
////////////////////////////////////////////////////////////
package pic_command_pkg;

    typedef struct packed {
        logic                      rotate;
        logic                      specific;
        logic                      eoi;
        logic [1:0]                fixed;
        pic_level_pkg::level_num_t level;
    } ocw2_view_t;

    typedef struct packed {
        logic       reserved;
        logic [1:0] special_mask;
        logic [1:0] fixed;
        logic       poll;
        logic [1:0] read_register;
    } ocw3_view_t;

    typedef union packed {
        ocw2_view_t ocw2_view;
        ocw3_view_t ocw3_view;
    } command_word_u;

    typedef enum logic [2:0] {
        READY,
        WAIT_ACK,
        ACK1,
        ACK2,
        POLL
    } ack_state_t;

    // Bit 7 of a poll answer when a level was found
    localparam logic POLL_FLAG = 1'b1;

endpackage

// ==== logic/pic_control_logic.sv ====
////////////////////////////////////////////////////////////
// Control block of an 8-level interrupt controller
// Single mode, 8086 host; joins the command decoder, the
// acknowledge sequencer and the data bus driver
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module pic_control_logic
    import pic_level_pkg::*;
    import pic_command_pkg::*;
(
    input   logic           clock,
    input   logic           reset,

    // Host writes and reads
    input   logic   [7:0]   data_in,
    input   logic           write_icw1,
    input   logic           write_icw2_4,
    input   logic           write_ocw1,
    input   logic           write_ocw2,
    input   logic           write_ocw3,
    input   logic           read,
    input   logic           interrupt_acknowledge_n,
    output  logic           interrupt_to_cpu,
    output  logic           data_enable,
    output  logic   [7:0]   data_out,

    // Request and in-service logic
    input   level_vector_t  interrupt,
    input   level_vector_t  highest_level_in_service,
    output  level_vector_t  interrupt_mask,
    output  level_vector_t  end_of_interrupt,
    output  logic           freeze,
    output  logic           latch_in_service,
    output  level_vector_t  clear_interrupt_request,
    output  logic           level_triggered_config
);
    vector_base_t   vector_base;
    logic           auto_eoi_config;
    logic           ocw2_accepted;
    logic           poll_command;
    logic           nonspecific_eoi;
    level_vector_t  specific_eoi;
    ack_state_t     ack_state;
    level_vector_t  acknowledged_interrupt;

    command_word_decoder decoder0 (
        .clock                  (clock),
        .reset                  (reset),
        .data_in                (data_in),
        .write_icw1             (write_icw1),
        .write_icw2_4           (write_icw2_4),
        .write_ocw1             (write_ocw1),
        .write_ocw2             (write_ocw2),
        .write_ocw3             (write_ocw3),
        .vector_base            (vector_base),
        .level_triggered_config (level_triggered_config),
        .auto_eoi_config        (auto_eoi_config),
        .interrupt_mask         (interrupt_mask),
        .ocw2_accepted          (ocw2_accepted),
        .poll_command           (poll_command),
        .nonspecific_eoi        (nonspecific_eoi),
        .specific_eoi           (specific_eoi)
    );

    acknowledge_sequencer sequencer0 (
        .clock                    (clock),
        .reset                    (reset),
        .write_icw1               (write_icw1),
        .interrupt_acknowledge_n  (interrupt_acknowledge_n),
        .read                     (read),
        .interrupt                (interrupt),
        .highest_level_in_service (highest_level_in_service),
        .ocw2_accepted            (ocw2_accepted),
        .poll_command             (poll_command),
        .nonspecific_eoi          (nonspecific_eoi),
        .specific_eoi             (specific_eoi),
        .auto_eoi_config          (auto_eoi_config),
        .ack_state                (ack_state),
        .acknowledged_interrupt   (acknowledged_interrupt),
        .interrupt_to_cpu         (interrupt_to_cpu),
        .freeze                   (freeze),
        .latch_in_service         (latch_in_service),
        .clear_interrupt_request  (clear_interrupt_request),
        .end_of_interrupt         (end_of_interrupt)
    );

    vector_output output0 (
        .ack_state               (ack_state),
        .acknowledged_interrupt  (acknowledged_interrupt),
        .vector_base             (vector_base),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .read                    (read),
        .data_enable             (data_enable),
        .data_out                (data_out)
    );

endmodule

// ==== logic/pic_level_pkg.sv ====
////////////////////////////////////////////////////////////
// Interrupt level definitions shared by the controller
// Level vectors, level numbers, the ICW2 vector base and
// conversions between level numbers and one-hot vectors
////////////////////////////////////////////////////////////
package pic_level_pkg;

    localparam int NUM_LEVELS = 8;

    typedef logic [NUM_LEVELS-1:0]         level_vector_t;
    typedef logic [$clog2(NUM_LEVELS)-1:0] level_num_t;
    typedef logic [4:0]                    vector_base_t;

    function automatic level_vector_t level_to_onehot(input level_num_t level);
        level_vector_t onehot;
        onehot        = '0;
        onehot[level] = 1'b1;
        return onehot;
    endfunction

    // Lowest set bit wins
    function automatic level_num_t onehot_to_level(input level_vector_t onehot);
        level_num_t level;
        level = '0;
        for (int i = NUM_LEVELS - 1; i >= 0; i--) begin
            if (onehot[i])
                level = level_num_t'(i);
        end
        return level;
    endfunction

endpackage

// ==== logic/vector_output.sv ====
////////////////////////////////////////////////////////////
// Data bus driver for acknowledge and poll reads
// Puts the vector on the bus in the second INTA pulse and
// the poll answer while a poll read is active
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module vector_output
    import pic_level_pkg::*;
    import pic_command_pkg::*;
(
    input   ack_state_t     ack_state,
    input   level_vector_t  acknowledged_interrupt,
    input   vector_base_t   vector_base,
    input   logic           interrupt_acknowledge_n,
    input   logic           read,
    output  logic           data_enable,
    output  logic   [7:0]   data_out
);
    level_num_t acknowledged_level;

    assign acknowledged_level = onehot_to_level(acknowledged_interrupt);

    always_comb begin
        data_enable = 1'b0;
        data_out    = 8'h00;
        if ((ack_state == ACK2) && !interrupt_acknowledge_n) begin
            // 8086 vector is T7-T3 plus the level
            data_enable = 1'b1;
            data_out    = {vector_base, acknowledged_level};
        end else if ((ack_state == POLL) && read) begin
            data_enable = 1'b1;
            if (acknowledged_interrupt != '0)
                data_out = {POLL_FLAG, 4'b0000, acknowledged_level};
        end
    end

endmodule

// ==== project.f ====
logic/pic_level_pkg.sv
logic/pic_command_pkg.sv
logic/command_word_decoder.sv
logic/acknowledge_sequencer.sv
logic/vector_output.sv
logic/pic_control_logic.sv
verification/pic_control_logic_checker.sv
verification/pic_control_logic_tb.sv

// ==== verification/pic_control_logic_checker.sv ====
////////////////////////////////////////////////////////////
// Protocol assertions on the control block outputs
// Bound into every pic_control_logic instance
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module pic_control_logic_checker
    import pic_level_pkg::*;
(
    input   logic           clock,
    input   logic           reset,
    input   logic           latch_in_service,
    input   level_vector_t  end_of_interrupt,
    input   logic           data_enable,
    input   logic           interrupt_acknowledge_n,
    input   logic           read
);
    int failure_count = 0;

    // In-service latch is a single-cycle strobe
    latch_pulse: assert property (@(posedge clock) disable iff (reset)
        latch_in_service |=> !latch_in_service)
        else begin
            failure_count++;
            $error("latch_in_service held high for two cycles");
        end

    eoi_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(end_of_interrupt))
        else begin
            failure_count++;
            $error("end_of_interrupt has more than one bit set");
        end

    // Bus only driven inside INTA or a poll read
    bus_idle: assert property (@(posedge clock) disable iff (reset)
        !(data_enable && interrupt_acknowledge_n && !read))
        else begin
            failure_count++;
            $error("data_enable high with neither INTA nor read active");
        end

endmodule

bind pic_control_logic pic_control_logic_checker checker0 (
    .clock                   (clock),
    .reset                   (reset),
    .latch_in_service        (latch_in_service),
    .end_of_interrupt        (end_of_interrupt),
    .data_enable             (data_enable),
    .interrupt_acknowledge_n (interrupt_acknowledge_n),
    .read                    (read)
);

// ==== verification/pic_control_logic_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the interrupt controller control block
// Runs initialization, acknowledge, EOI and poll sequences
// and checks the outputs against independently built values
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module pic_control_logic_tb
    import pic_level_pkg::*;
();
    localparam int WAIT_LIMIT = 50;

    // Strobe bits in order icw1, icw2_4, ocw1, ocw2, ocw3
    localparam logic [4:0] ICW1   = 5'b10000;
    localparam logic [4:0] ICW2_4 = 5'b01000;
    localparam logic [4:0] OCW1   = 5'b00100;
    localparam logic [4:0] OCW2   = 5'b00010;
    localparam logic [4:0] OCW3   = 5'b00001;

    logic           clock;
    logic           reset;
    logic   [7:0]   data_in;
    logic           write_icw1;
    logic           write_icw2_4;
    logic           write_ocw1;
    logic           write_ocw2;
    logic           write_ocw3;
    logic           read;
    logic           interrupt_acknowledge_n;
    logic           interrupt_to_cpu;
    logic           data_enable;
    logic   [7:0]   data_out;
    level_vector_t  interrupt;
    level_vector_t  highest_level_in_service;
    level_vector_t  interrupt_mask;
    level_vector_t  end_of_interrupt;
    logic           freeze;
    logic           latch_in_service;
    level_vector_t  clear_interrupt_request;
    logic           level_triggered_config;

    integer         seed = 74;
    int             error_count = 0;
    int             test_errors = 0;
    int             tests_passed = 0;
    int             tests_failed = 0;
    logic   [7:0]   expected_bytes[$];
    level_vector_t  strobe_clear_request;
    level_vector_t  strobe_eoi;
    vector_base_t   base;
    level_num_t     level;
    level_vector_t  mask;

    pic_control_logic dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // 8086 vector holds T7-T3 from ICW2 and the level in the low three bits
    function automatic logic [7:0] expected_vector(input vector_base_t vector_base,
                                                   input level_num_t lvl);
        return {vector_base, lvl};
    endfunction

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] expected);
        if (got !== expected) begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_levels(input string name, input level_vector_t got,
                                input level_vector_t expected);
        if (got !== expected) begin
            $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic end_test(input string name);
        if (error_count == test_errors) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: failed", name);
            tests_failed++;
        end
        test_errors = error_count;
    endtask

    task automatic finish_run();
        $display("%0d tests ok, %0d tests failed, %0d check errors",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    endtask

    // One-cycle strobe; bus outputs are captured mid-cycle
    task automatic write_word(input logic [4:0] strobes, input logic [7:0] value);
        {write_icw1, write_icw2_4, write_ocw1, write_ocw2, write_ocw3} = strobes;
        data_in = value;
        @(negedge clock);
        strobe_clear_request = clear_interrupt_request;
        strobe_eoi           = end_of_interrupt;
        step();
        {write_icw1, write_icw2_4, write_ocw1, write_ocw2, write_ocw3} = 5'b00000;
        data_in = 8'h00;
    endtask

    // Single mode with ICW4, 8086 host
    task automatic initialize(input vector_base_t vector_base, input logic level_mode,
                              input logic auto_eoi);
        write_word(ICW1, {4'b0001, level_mode, 3'b011});
        check_levels("clear_interrupt_request", strobe_clear_request, '1);
        check_bit("level_triggered_config", level_triggered_config, level_mode);
        write_word(ICW2_4, {vector_base, 3'b000});
        write_word(ICW2_4, {6'b000000, auto_eoi, 1'b1});
    endtask

    task automatic wait_for_request();
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !seen; i++) begin
            @(negedge clock);
            seen = interrupt_to_cpu;
        end
        if (!seen) begin
            $display("Timeout: interrupt_to_cpu never rose after a request");
            error_count++;
            finish_run();
        end else begin
            step();
        end
    endtask

    task automatic acknowledge(input vector_base_t vector_base, input level_num_t lvl,
                               input logic auto_eoi);
        level_vector_t onehot;
        onehot = level_vector_t'(1) << lvl;
        interrupt = onehot;
        wait_for_request();
        interrupt_acknowledge_n = 1'b0;
        @(negedge clock);
        check_bit("latch_in_service", latch_in_service, 1'b1);
        check_levels("clear_interrupt_request", clear_interrupt_request, onehot);
        step();
        check_bit("freeze", freeze, 1'b1);
        interrupt = '0;
        step();
        interrupt_acknowledge_n = 1'b1;
        step();
        // Second pulse carries the vector
        expected_bytes.push_back(expected_vector(vector_base, lvl));
        interrupt_acknowledge_n = 1'b0;
        @(negedge clock);
        check_bit("data_enable", data_enable, 1'b1);
        step();
        interrupt_acknowledge_n = 1'b1;
        @(negedge clock);
        check_levels("end_of_interrupt", end_of_interrupt,
                     auto_eoi ? onehot : level_vector_t'(0));
        step();
        check_bit("interrupt_to_cpu", interrupt_to_cpu, 1'b0);
        check_bit("freeze", freeze, 1'b0);
    endtask

    task automatic poll_levels(input logic pending, input level_num_t lvl);
        logic [7:0] answer;
        answer = pending ? {1'b1, 4'b0000, lvl} : 8'h00;
        if (pending) begin
            interrupt = level_vector_t'(1) << lvl;
            wait_for_request();
        end
        write_word(OCW3, 8'h0C);
        interrupt = '0;
        expected_bytes.push_back(answer);
        read = 1'b1;
        @(negedge clock);
        check_bit("data_enable", data_enable, 1'b1);
        step();
        read = 1'b0;
        step();
        check_bit("interrupt_to_cpu", interrupt_to_cpu, 1'b0);
    endtask

    // Every byte the DUT puts on the bus is matched against the queue
    always @(negedge clock) begin
        if (!reset && data_enable) begin
            if (expected_bytes.size() == 0) begin
                $display("Unexpected data_enable at %0t ns with data_out %h", $time, data_out);
                error_count++;
            end else begin
                check_byte("data_out", data_out, expected_bytes.pop_front());
            end
        end
    end

    initial begin
        reset                    = 1'b1;
        data_in                  = 8'h00;
        write_icw1               = 1'b0;
        write_icw2_4             = 1'b0;
        write_ocw1               = 1'b0;
        write_ocw2               = 1'b0;
        write_ocw3               = 1'b0;
        read                     = 1'b0;
        interrupt_acknowledge_n  = 1'b1;
        interrupt                = '0;
        highest_level_in_service = '0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        check_levels("interrupt_mask", interrupt_mask, '1);
        check_bit("interrupt_to_cpu", interrupt_to_cpu, 1'b0);
        check_bit("data_enable", data_enable, 1'b0);
        check_bit("freeze", freeze, 1'b1);
        check_bit("level_triggered_config", level_triggered_config, 1'b0);
        end_test("reset values");
        step();

        base = vector_base_t'($random(seed));
        initialize(base, 1'b0, 1'b0);
        mask = level_vector_t'($random(seed));
        write_word(OCW1, mask);
        check_levels("interrupt_mask", interrupt_mask, mask);
        end_test("initialization and mask");

        level = level_num_t'($random(seed));
        acknowledge(base, level, 1'b0);
        end_test("acknowledge sequence");

        base = vector_base_t'($random(seed));
        initialize(base, 1'b1, 1'b1);
        level = level_num_t'($random(seed));
        acknowledge(base, level, 1'b1);
        end_test("automatic EOI");

        level = level_num_t'($random(seed));
        highest_level_in_service = level_vector_t'(1) << level;
        write_word(OCW2, 8'h20);
        check_levels("end_of_interrupt", strobe_eoi, highest_level_in_service);
        highest_level_in_service = '0;
        level = level_num_t'($random(seed));
        write_word(OCW2, {5'b01100, level});
        check_levels("end_of_interrupt", strobe_eoi, level_vector_t'(1) << level);
        end_test("OCW2 end of interrupt");

        level = level_num_t'($random(seed));
        poll_levels(1'b1, level);
        poll_levels(1'b0, 3'd0);
        end_test("poll");

        if (expected_bytes.size() != 0) begin
            $display("A vector or poll byte never appeared on the data bus");
            error_count++;
        end
        if (dut0.checker0.failure_count != 0) begin
            $display("The bound checker saw %0d assertion failures",
                     dut0.checker0.failure_count);
            error_count += dut0.checker0.failure_count;
        end
        finish_run();
    end

endmodule
